//--- Makefile
TOP := tb_hub

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- board_link_if.sv
// Board port to hub store link
`timescale 1ns/1ps

interface board_link_if #(
    parameter int QUADS_PER_BOARD = 5
);
    import hub_pkg::*;

    localparam int IDX_W = idx_w(QUADS_PER_BOARD);

    // Four-phase handshake, req from the port and ack from the store
    logic             req;
    logic             ack;
    // The store walks the buffer by index and the port answers with that quadlet
    logic [IDX_W-1:0] quad_idx;
    quad_t            quad;

    modport port (output req, output quad, input ack, input quad_idx);
    modport store (input req, input quad, output ack, output quad_idx);

endinterface

//--- board_port.sv
// Board status port
`timescale 1ns/1ps

module board_port #(
    parameter int QUADS_PER_BOARD = 5
) (
    input  logic           sysclk,
    input  logic           rst_n,
    input  hub_pkg::seq_t  query_seq,
    input  logic           mask_bit,
    input  logic           query_start,
    input  logic           bd_valid,
    input  hub_pkg::quad_t bd_quad,
    board_link_if.port     link
);
    import hub_pkg::*;

    localparam int IDX_W = idx_w(QUADS_PER_BOARD);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(QUADS_PER_BOARD - 1);

    // Packet buffer, frozen while req is high
    quad_t            pkt_buf [QUADS_PER_BOARD];
    // Position inside the current packet, counted for every packet on the wire
    logic [IDX_W-1:0] cnt;
    logic             keep;
    logic             done;
    logic             first_ok;
    logic             capture;

    // The first quadlet decides whether the packet is taken.
    // A busy handshake or an earlier packet for this query means a drop
    assign first_ok = (cnt == '0) && mask_bit && (bd_quad[31:16] == query_seq) &&
                      !done && !link.req && !link.ack;
    assign capture = bd_valid && (keep || first_ok);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            keep     <= 1'b0;
            done     <= 1'b0;
            link.req <= 1'b0;
        end else begin
            if (bd_valid) begin
                cnt <= (cnt == LAST_IDX) ? '0 : cnt + 1'b1;
            end
            // Last quadlet of a kept packet starts the handshake on the next cycle
            if (capture && (cnt == LAST_IDX)) begin
                keep     <= 1'b0;
                done     <= 1'b1;
                link.req <= 1'b1;
            end else if (capture) begin
                keep <= 1'b1;
            end
            // Phase 3, the store has copied the buffer
            if (link.req && link.ack) begin
                link.req <= 1'b0;
            end
            // A new query allows one more packet from this board
            if (query_start) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (capture) begin
            pkt_buf[cnt] <= bd_quad;
        end
    end

    // The store picks quadlets by index during its copy phase
    assign link.quad = pkt_buf[link.quad_idx];

    // Once raised, req holds until the store has acknowledged
    assert property (@(posedge sysclk) disable iff (!rst_n)
                     link.req && !link.ack |=> link.req)
        else $error("board_port: req dropped before ack");

endmodule

//--- hub_pkg.sv
// Hub shared definitions
package hub_pkg;

    // One 32-bit quadlet as seen by the host and the boards
    typedef logic [31:0] quad_t;

    // Query sequence number carried in the upper half of a first quadlet
    typedef logic [15:0] seq_t;

    // Query timer, counts sysclk cycles since the last broadcast query
    typedef logic [13:0] stamp_t;

    // Host address; bit 7 set selects register space
    typedef logic [7:0] haddr_t;

    // Register space base, 0x80 is the query word and 0x81 the read-index list
    localparam haddr_t HUB_REG_BASE = 8'h80;

    // Status codes placed in bits 15:14 of a board's first quadlet
    localparam logic [1:0] FLAG_UPDATED = 2'b10;
    localparam logic [1:0] FLAG_STALE   = 2'b00;

    // Store arbitration: wait, copy quadlets, hold ack, then drop ack
    typedef enum logic [1:0] {
        IDLE,
        COPY,
        ACK,
        DROP
    } store_state_t;

    // Index width for n entries, never below one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

//--- hub_query.sv
// Host query register
`timescale 1ns/1ps

module hub_query #(
    parameter int NUM_BOARDS = 4
) (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  reg_wen,
    input  hub_pkg::haddr_t       reg_waddr,
    input  hub_pkg::quad_t        reg_wdata,
    output hub_pkg::seq_t         query_seq,
    output logic [NUM_BOARDS-1:0] query_mask,
    output logic                  query_start,
    output hub_pkg::stamp_t       timer
);
    import hub_pkg::*;

    logic query_wen;
    logic mask_nonzero;

    // Only the query word at the register base is writable
    assign query_wen = reg_wen && (reg_waddr == HUB_REG_BASE);

    // A zero mask would leave the read-index list with nothing to cycle over
    assign mask_nonzero = (reg_wdata[NUM_BOARDS-1:0] != '0);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            query_seq   <= '0;
            query_mask  <= '1;
            query_start <= 1'b0;
            timer       <= '0;
        end else begin
            // One-cycle pulse that lines up with the new sequence and mask
            query_start <= query_wen;
            if (query_wen) begin
                query_seq <= reg_wdata[31:16];
                if (mask_nonzero) begin
                    query_mask <= reg_wdata[NUM_BOARDS-1:0];
                end
                // Timestamps are relative to the query, so restart the count
                timer <= '0;
            end else begin
                // Free-running, wraps after 16k cycles
                timer <= timer + 1'b1;
            end
        end
    end

    // The store and the list builder rely on at least one enabled board
    assert property (@(posedge sysclk) disable iff (!rst_n) query_mask != '0)
        else $error("hub_query: board mask became zero");

endmodule

//--- hub_store.sv
// Hub memory and read translation
`timescale 1ns/1ps

module hub_store #(
    parameter int NUM_BOARDS      = 4,
    parameter int QUADS_PER_BOARD = 5,
    parameter int SLOT_QUADS      = 8
) (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  query_start,
    input  hub_pkg::stamp_t       timer,
    input  logic [NUM_BOARDS-1:0] query_mask,
    input  hub_pkg::haddr_t       reg_raddr,
    input  hub_pkg::seq_t         query_seq,
    board_link_if.store           links [NUM_BOARDS],
    output hub_pkg::quad_t        reg_rdata
);
    import hub_pkg::*;

    localparam int BW    = idx_w(NUM_BOARDS);
    localparam int SW    = idx_w(SLOT_QUADS);
    localparam int IDX_W = idx_w(QUADS_PER_BOARD);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(QUADS_PER_BOARD - 1);
    localparam haddr_t NQ = haddr_t'(QUADS_PER_BOARD);

    store_state_t            state;
    logic [BW-1:0]           cur;
    logic [BW-1:0]           rr_ptr;
    logic [IDX_W-1:0]        copy_idx;
    logic [NUM_BOARDS-1:0]   link_req;
    logic [NUM_BOARDS-1:0]   ack_vec;
    quad_t                   link_quad [NUM_BOARDS];
    logic [NUM_BOARDS-1:0]   updated;
    quad_t                   mem [NUM_BOARDS * SLOT_QUADS];
    quad_t                   wr_data;
    logic [BW-1:0]           read_index [NUM_BOARDS];
    logic [BW-1:0]           ib_entry;
    logic [BW-1:0]           ib_board;
    logic [NUM_BOARDS-1:0]   last_mask;
    logic                    rebuild;
    haddr_t                  mult_nq;
    logic [BW-1:0]           ent;
    logic                    at_boundary;
    logic [BW-1:0]           rd_entry;
    haddr_t                  rd_offset;
    logic [BW-1:0]           rd_board;
    quad_t                   mem_word;
    quad_t                   list_word;

    // First set bit of vec at or after start, going round
    function automatic logic [BW-1:0] first_from(input logic [NUM_BOARDS-1:0] vec,
                                                 input logic [BW-1:0] start);
        logic [BW-1:0] pick;
        logic [BW-1:0] cand;
        logic          found;
        pick  = start;
        found = 1'b0;
        for (int j = 0; j < NUM_BOARDS; j++) begin
            cand = start + BW'(j);
            if (!found && vec[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // Interface arrays only take constant indices, so flatten them here
    for (genvar g = 0; g < NUM_BOARDS; g++) begin : g_link
        assign link_req[g]       = links[g].req;
        assign link_quad[g]      = links[g].quad;
        assign ack_vec[g]        = (state == ACK) && (cur == BW'(g));
        assign links[g].ack      = ack_vec[g];
        assign links[g].quad_idx = copy_idx;

        // Phase 2 never starts without a pending request
        assert property (@(posedge sysclk) disable iff (!rst_n)
                         $rose(ack_vec[g]) |-> link_req[g])
            else $error("hub_store: ack raised without req on board %0d", g);
    end

    // Round-robin arbitration over the pending ports
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            cur      <= '0;
            rr_ptr   <= '0;
            copy_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (link_req != '0) begin
                        cur      <= first_from(link_req, rr_ptr);
                        copy_idx <= '0;
                        state    <= COPY;
                    end
                end
                COPY: begin
                    // One quadlet per cycle, ack follows the last one
                    if (copy_idx == LAST_IDX) begin
                        state <= ACK;
                    end else begin
                        copy_idx <= copy_idx + 1'b1;
                    end
                end
                ACK: begin
                    if (!link_req[cur]) begin
                        state <= DROP;
                    end
                end
                DROP: begin
                    // Ack is low again, next search starts past this board
                    rr_ptr <= cur + 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Quadlet 0 carries the update flag and the arrival time
    assign wr_data = (copy_idx == '0) ?
                     {link_quad[cur][31:16], FLAG_UPDATED, timer} : link_quad[cur];

    always_ff @(posedge sysclk) begin
        if (state == COPY) begin
            mem[{cur, SW'(copy_idx)}] <= wr_data;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            updated <= '0;
        end else if (query_start) begin
            updated <= '0;
        end else if ((state == COPY) && (copy_idx == '0)) begin
            updated[cur] <= 1'b1;
        end
    end

    // The list is refilled one entry per cycle whenever the mask moves
    assign rebuild = !query_start && (query_mask != last_mask);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ib_entry  <= '0;
            ib_board  <= '0;
            last_mask <= '0;
        end else if (query_start) begin
            ib_entry <= '0;
            ib_board <= '0;
        end else if (rebuild) begin
            ib_entry <= ib_entry + 1'b1;
            ib_board <= first_from(query_mask, ib_board) + 1'b1;
            if (ib_entry == BW'(NUM_BOARDS - 1)) begin
                last_mask <= query_mask;
            end
        end
    end

    // Entries repeat cyclically, e.g. mask 1010 gives 1,3,1,3
    always_ff @(posedge sysclk) begin
        if (rebuild) begin
            read_index[ib_entry] <= first_from(query_mask, ib_board);
        end
    end

    // Sequential host reads step through the enabled boards in list order.
    // mult_nq marks the address where the next entry begins
    assign at_boundary = (reg_raddr == mult_nq);
    assign rd_entry    = at_boundary ? ent + 1'b1 : ent;
    assign rd_offset   = at_boundary ? '0 : reg_raddr - (mult_nq - NQ);
    assign rd_board    = read_index[rd_entry];
    assign mem_word    = mem[{rd_board, rd_offset[SW-1:0]}];

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            mult_nq <= NQ;
            ent     <= '0;
        end else if (query_start || (reg_raddr == '0)) begin
            // Reading address 0 restarts the walk so the host can read again
            mult_nq <= NQ;
            ent     <= '0;
        end else if (!reg_raddr[7] && at_boundary) begin
            mult_nq <= mult_nq + NQ;
            ent     <= ent + 1'b1;
        end
    end

    // Packed list, entry 0 in the top nibble
    always_comb begin
        list_word = '0;
        for (int i = 0; i < NUM_BOARDS; i++) begin
            list_word[31 - 4 * i -: 4] = 4'(read_index[i]);
        end
    end

    always_ff @(posedge sysclk) begin
        if (reg_raddr == HUB_REG_BASE) begin
            reg_rdata <= {query_seq, 16'(query_mask)};
        end else if (reg_raddr == haddr_t'(HUB_REG_BASE + 1)) begin
            reg_rdata <= list_word;
        end else if (!reg_raddr[7]) begin
            // A board that has not answered shows the live timer and flag 00
            if ((rd_offset == '0) && !updated[rd_board]) begin
                reg_rdata <= {mem_word[31:16], FLAG_STALE, timer};
            end else begin
                reg_rdata <= mem_word;
            end
        end else begin
            reg_rdata <= '0;
        end
    end

endmodule

//--- hub_top.sv
// Status hub top level
`timescale 1ns/1ps

module hub_top #(
    parameter int NUM_BOARDS      = 4,
    parameter int QUADS_PER_BOARD = 5,
    parameter int SLOT_QUADS      = 8
) (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  logic                       reg_wen,
    input  hub_pkg::haddr_t            reg_waddr,
    input  hub_pkg::quad_t             reg_wdata,
    input  hub_pkg::haddr_t            reg_raddr,
    input  logic [NUM_BOARDS-1:0]      bd_valid,
    input  logic [NUM_BOARDS*32-1:0]   bd_quad,
    output hub_pkg::quad_t             reg_rdata
);
    import hub_pkg::*;

    seq_t                  query_seq;
    logic [NUM_BOARDS-1:0] query_mask;
    logic                  query_start;
    stamp_t                timer;

    // One handshake link per board
    board_link_if #(.QUADS_PER_BOARD(QUADS_PER_BOARD)) links [NUM_BOARDS] ();

    hub_query #(
        .NUM_BOARDS (NUM_BOARDS)
    ) hub_query_inst (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .query_seq   (query_seq),
        .query_mask  (query_mask),
        .query_start (query_start),
        .timer       (timer)
    );

    // Each port sees its own mask bit and its own slice of the board bus
    for (genvar g = 0; g < NUM_BOARDS; g++) begin : g_port
        board_port #(
            .QUADS_PER_BOARD (QUADS_PER_BOARD)
        ) board_port_inst (
            .sysclk      (sysclk),
            .rst_n       (rst_n),
            .query_seq   (query_seq),
            .mask_bit    (query_mask[g]),
            .query_start (query_start),
            .bd_valid    (bd_valid[g]),
            .bd_quad     (bd_quad[g*32 +: 32]),
            .link        (links[g])
        );
    end

    hub_store #(
        .NUM_BOARDS      (NUM_BOARDS),
        .QUADS_PER_BOARD (QUADS_PER_BOARD),
        .SLOT_QUADS      (SLOT_QUADS)
    ) hub_store_inst (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .query_start (query_start),
        .timer       (timer),
        .query_mask  (query_mask),
        .reg_raddr   (reg_raddr),
        .query_seq   (query_seq),
        .links       (links),
        .reg_rdata   (reg_rdata)
    );

endmodule

//--- src.f
hub_pkg.sv
board_link_if.sv
hub_query.sv
board_port.sv
hub_store.sv
hub_top.sv
tb_clkgen.sv
tb_hub.sv

//--- tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic sysclk,
    output logic rst_n
);

    // Free-running clock, first rising edge half a period in
    initial begin
        sysclk = 1'b0;
        forever #(PERIOD_NS / 2) sysclk = ~sysclk;
    end

    // Reset lets go just after an edge so no flop sees it change at the edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tb_hub.sv
// Status hub testbench
`timescale 1ns/1ps

module tb_hub;

    localparam int NUM_BOARDS      = 4;
    localparam int QUADS_PER_BOARD = 5;
    localparam int SLOT_QUADS      = 8;
    localparam int NUM_STEPS       = 30;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * 200 + 500;
    // Storage is not visible at the pins, so packets get a fixed margin
    localparam int SETTLE_CYCLES   = 64;

    typedef enum logic [1:0] {OP_QUERY, OP_PKT, OP_SEND, OP_CHECK} op_t;

    // One table row; unused fields are zero
    typedef struct packed {
        op_t         op;
        logic [1:0]  board;
        logic [15:0] seq;
        logic [3:0]  mask;
        logic [15:0] seed;
    } step_t;

    logic                     sysclk;
    logic                     rst_n;
    logic                     reg_wen;
    logic [7:0]               reg_waddr;
    logic [31:0]              reg_wdata;
    logic [7:0]               reg_raddr;
    logic [NUM_BOARDS-1:0]    bd_valid;
    logic [NUM_BOARDS*32-1:0] bd_quad;
    logic [31:0]              reg_rdata;

    // Reference model of the hub as the host should see it
    logic [15:0]           m_seq;
    logic [NUM_BOARDS-1:0] m_mask;
    logic [NUM_BOARDS-1:0] m_updated;
    logic [NUM_BOARDS-1:0] m_done;
    logic [NUM_BOARDS-1:0] m_stored;
    logic [31:0]           m_mem [NUM_BOARDS][QUADS_PER_BOARD];
    // Packets waiting to go out together on the next send
    logic [NUM_BOARDS-1:0] staged;
    logic [31:0]           stage_buf [NUM_BOARDS][QUADS_PER_BOARD];
    step_t                 steps [NUM_STEPS];
    int                    checks;

    tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(3)) tb_clkgen_inst (
        .sysclk (sysclk),
        .rst_n  (rst_n)
    );

    hub_top #(
        .NUM_BOARDS      (NUM_BOARDS),
        .QUADS_PER_BOARD (QUADS_PER_BOARD),
        .SLOT_QUADS      (SLOT_QUADS)
    ) hub_top_inst (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_raddr (reg_raddr),
        .bd_valid  (bd_valid),
        .bd_quad   (bd_quad),
        .reg_rdata (reg_rdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Only the bits set in care are compared
    task automatic check_quad(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic [31:0] care);
        checks++;
        assert ((got & care) == (exp & care)) else begin
            abort_run($sformatf("MISMATCH %s got %08h expected %08h care %08h",
                                name, got, exp, care));
        end
    endtask

    // Enabled boards in ascending order, repeated to fill every entry
    function automatic logic [31:0] expected_list(input logic [NUM_BOARDS-1:0] mask);
        int          en [$];
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < NUM_BOARDS; b++) begin
            if (mask[b]) begin
                en.push_back(b);
            end
        end
        for (int i = 0; i < NUM_BOARDS; i++) begin
            w[31 - 4 * i -: 4] = 4'(en[i % en.size()]);
        end
        return w;
    endfunction

    // All tasks below start and end 1 ns after a rising edge
    task automatic write_query(input logic [15:0] seq, input logic [NUM_BOARDS-1:0] mask);
        reg_wen   = 1'b1;
        reg_waddr = 8'h80;
        reg_wdata = {seq, 12'h000, mask};
        @(posedge sysclk);
        #1;
        reg_wen = 1'b0;
        m_seq   = seq;
        // A zero mask keeps the previous one
        if (mask != '0) begin
            m_mask = mask;
        end
        m_updated = '0;
        m_done    = '0;
        repeat (2 * NUM_BOARDS) @(posedge sysclk);
        #1;
    endtask

    task automatic read_addr(input logic [7:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        @(posedge sysclk);
        #1;
        data = reg_rdata;
    endtask

    task automatic stage_packet(input logic [1:0] board, input logic [15:0] seq,
                                input logic [15:0] seed);
        // The seed marks the first quadlet and scrambles the random payload
        stage_buf[board][0] = {seq, seed};
        for (int k = 1; k < QUADS_PER_BOARD; k++) begin
            stage_buf[board][k] = $urandom() ^ {seed, seed};
        end
        staged[board] = 1'b1;
    endtask

    task automatic send_staged();
        for (int k = 0; k < QUADS_PER_BOARD; k++) begin
            bd_valid = staged;
            for (int b = 0; b < NUM_BOARDS; b++) begin
                bd_quad[b * 32 +: 32] = staged[b] ? stage_buf[b][k] : 32'h0;
            end
            @(posedge sysclk);
            #1;
        end
        bd_valid = '0;
        bd_quad  = '0;
        // One packet per enabled board with the current sequence
        for (int b = 0; b < NUM_BOARDS; b++) begin
            if (staged[b] && m_mask[b] && !m_done[b] &&
                (stage_buf[b][0][31:16] == m_seq)) begin
                for (int k = 0; k < QUADS_PER_BOARD; k++) begin
                    m_mem[b][k] = stage_buf[b][k];
                end
                m_updated[b] = 1'b1;
                m_done[b]    = 1'b1;
                m_stored[b]  = 1'b1;
            end
        end
        staged = '0;
        repeat (SETTLE_CYCLES) @(posedge sysclk);
        #1;
    endtask

    task automatic check_registers();
        logic [31:0] w;
        read_addr(8'h80, w);
        check_quad("reg_rdata @80", w, {m_seq, 12'h000, m_mask}, 32'hFFFF_FFFF);
        read_addr(8'h81, w);
        check_quad("reg_rdata @81", w, expected_list(m_mask), 32'hFFFF_FFFF);
    endtask

    // Walks the first two list entries from address 0
    task automatic check_walk();
        logic [31:0] w;
        logic [31:0] list;
        logic [31:0] exp;
        logic [31:0] care;
        int          b;
        int          k;
        list = expected_list(m_mask);
        // One idle cycle at address 0 restarts the translation
        reg_raddr = 8'h00;
        @(posedge sysclk);
        #1;
        for (int a = 0; a < 2 * QUADS_PER_BOARD; a++) begin
            b = int'(list[31 - 4 * (a / QUADS_PER_BOARD) -: 4]);
            k = a % QUADS_PER_BOARD;
            exp  = '0;
            care = '0;
            if (k == 0) begin
                // Timer field is never compared
                care = m_stored[b] ? 32'hFFFF_C000 : 32'h0000_C000;
                exp  = {m_mem[b][0][31:16], m_updated[b] ? 2'b10 : 2'b00, 14'h0};
            end else if (m_stored[b]) begin
                care = 32'hFFFF_FFFF;
                exp  = m_mem[b][k];
            end
            read_addr(8'(a), w);
            // The payload of a slot that never took a packet is unknown
            if (care != '0) begin
                check_quad($sformatf("reg_rdata @%02h", a), w, exp, care);
            end
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_QUERY: write_query(s.seq, s.mask);
            OP_PKT:   stage_packet(s.board, s.seq, s.seed);
            OP_SEND:  send_staged();
            default: begin
                check_registers();
                check_walk();
                // A second pass from address 0 must give the same data
                check_walk();
            end
        endcase
    endtask

    task automatic fill_table();
        steps[0]  = '{OP_QUERY, 2'd0, 16'h1234, 4'hF, 16'h0000};
        steps[1]  = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        // Mask 0 changes the sequence only
        steps[2]  = '{OP_QUERY, 2'd0, 16'h5678, 4'h0, 16'h0000};
        // Board 0 fills its slot while the mask still enables it
        steps[3]  = '{OP_PKT,   2'd0, 16'h5678, 4'h0, 16'h00C1};
        steps[4]  = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[5]  = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[6]  = '{OP_QUERY, 2'd0, 16'h00A5, 4'hA, 16'h0000};
        steps[7]  = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[8]  = '{OP_PKT,   2'd1, 16'h00A5, 4'h0, 16'h0011};
        steps[9]  = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[10] = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        // Wrong sequence on board 1, board 0 outside the mask
        steps[11] = '{OP_QUERY, 2'd0, 16'h00A6, 4'h0, 16'h0000};
        steps[12] = '{OP_PKT,   2'd1, 16'h00A5, 4'h0, 16'h0022};
        steps[13] = '{OP_PKT,   2'd0, 16'h00A6, 4'h0, 16'h0033};
        steps[14] = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[15] = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        // Three boards at once, the store has to queue them
        steps[16] = '{OP_PKT,   2'd1, 16'h00A6, 4'h0, 16'h0044};
        steps[17] = '{OP_PKT,   2'd3, 16'h00A6, 4'h0, 16'h0055};
        steps[18] = '{OP_PKT,   2'd2, 16'h00A6, 4'h0, 16'h0066};
        steps[19] = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[20] = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[21] = '{OP_QUERY, 2'd0, 16'h0B0B, 4'hA, 16'h0000};
        steps[22] = '{OP_PKT,   2'd3, 16'h0B0B, 4'h0, 16'h0077};
        steps[23] = '{OP_PKT,   2'd1, 16'h0B0B, 4'h0, 16'h0088};
        steps[24] = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        // Second packet from board 1 in the same query is ignored
        steps[25] = '{OP_PKT,   2'd1, 16'h0B0B, 4'h0, 16'h0099};
        steps[26] = '{OP_SEND,  2'd0, 16'h0000, 4'h0, 16'h0000};
        steps[27] = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
        // Board 0 is enabled again and its slot still holds its first packet
        steps[28] = '{OP_QUERY, 2'd0, 16'h0C0C, 4'h1, 16'h0000};
        steps[29] = '{OP_CHECK, 2'd0, 16'h0000, 4'h0, 16'h0000};
    endtask

    initial begin
        void'($urandom(82));
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        bd_valid  = '0;
        bd_quad   = '0;
        m_seq     = '0;
        m_mask    = '1;
        m_updated = '0;
        m_done    = '0;
        m_stored  = '0;
        staged    = '0;
        checks    = 0;
        fill_table();
        @(posedge rst_n);
        @(posedge sysclk);
        #1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end
        if (checks > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("no checks were run");
        end
    end

    // Bound on the whole run in case the DUT or a task stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        abort_run($sformatf("timeout, run still busy after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule
